//--- common/cache_cfg_pkg.sv
package cache_cfg_pkg;

   // way count and way number width
   localparam int NWAYS   = 2;
   localparam int NWAYS_W = 1;

   // 8 sets
   localparam int NSETS_W = 3;
   localparam int NSETS   = 1 << NSETS_W;

   // 4 words per line
   localparam int WORDS_PER_LINE_W = 2;
   localparam int WORDS_PER_LINE   = 1 << WORDS_PER_LINE_W;

   // tag bits above index and word offset
   // the front-end address width is derived from this
   localparam int TAG_W = 7;

   // controller state codes
   localparam int ST_W = 2;
   localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;
   localparam logic [ST_W-1:0] ST_LOOKUP = 2'd1;
   localparam logic [ST_W-1:0] ST_REFILL = 2'd2;
   localparam logic [ST_W-1:0] ST_WRITE  = 2'd3;

endpackage

//--- common/cache_bus_pkg.sv
package cache_bus_pkg;

   // word address on both buses
   localparam int ADDR_W = cache_cfg_pkg::TAG_W + cache_cfg_pkg::NSETS_W
                           + cache_cfg_pkg::WORDS_PER_LINE_W;

   // data word and byte strobes
   localparam int DATA_W = 32;
   localparam int NBYTES = DATA_W / 8;

   // one cache line in bits
   localparam int LINE_W = cache_cfg_pkg::WORDS_PER_LINE * DATA_W;

   // front-end address, seen either as a flat word address
   // or split into tag, set index and word offset
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      struct packed {
         logic [cache_cfg_pkg::TAG_W-1:0]            tag;
         logic [cache_cfg_pkg::NSETS_W-1:0]          index;
         logic [cache_cfg_pkg::WORDS_PER_LINE_W-1:0] offset;
      } fields;
   } fe_addr_u;

endpackage

//--- src/cache_sp_ram.sv
`timescale 1ns/1ps

module cache_sp_ram #(
   parameter int WORD_W  = 32,
   parameter int DEPTH_W = 3,
   parameter int NGROUPS = 4
) (
   input  logic               clk_i,
   input  logic               en_i,
   input  logic [DEPTH_W-1:0] addr_i,
   input  logic [NGROUPS-1:0] we_i,
   input  logic [WORD_W-1:0]  d_i,
   output logic [WORD_W-1:0]  q_o
);

   logic [WORD_W-1:0] mem [2**DEPTH_W];

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         // each enable bit covers one slice of the word
         for (int g = 0; g < NGROUPS; g++) begin
            if (we_i[g]) begin
               mem[addr_i][g*(WORD_W/NGROUPS) +: WORD_W/NGROUPS] <=
                  d_i[g*(WORD_W/NGROUPS) +: WORD_W/NGROUPS];
            end
         end
         // read returns the contents before the write
         q_o <= mem[addr_i];
      end
   end

endmodule

//--- cache/cache_replace.sv
`timescale 1ns/1ps

module cache_replace (
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   input  logic [cache_cfg_pkg::NSETS_W-1:0] set_i,
   output logic [cache_cfg_pkg::NWAYS_W-1:0] replace_way_o,
   input  logic                              touch_i,
   input  logic [cache_cfg_pkg::NSETS_W-1:0] touch_set_i,
   input  logic [cache_cfg_pkg::NWAYS_W-1:0] touch_way_i
);

   // least recently used way of every set
   logic [cache_cfg_pkg::NSETS-1:0][cache_cfg_pkg::NWAYS_W-1:0] lru_q;

   // victim for the queried set
   assign replace_way_o = lru_q[set_i];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lru_q <= '0;
      end else if (touch_i) begin
         // with two ways the untouched one is now the oldest
         lru_q[touch_set_i] <= ~touch_way_i;
      end
   end

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                                    clk_i,
   input  logic                                    arst_n_i,
   // front-end bus
   input  logic                                    fe_avalid_i,
   input  logic [cache_bus_pkg::ADDR_W-1:0]        fe_addr_i,
   input  logic [cache_bus_pkg::DATA_W-1:0]        fe_wdata_i,
   input  logic [cache_bus_pkg::NBYTES-1:0]        fe_wstrb_i,
   output logic [cache_bus_pkg::DATA_W-1:0]        fe_rdata_o,
   output logic                                    fe_rvalid_o,
   output logic                                    fe_ready_o,
   // back-end bus
   output logic                                    be_avalid_o,
   output logic [cache_bus_pkg::ADDR_W-1:0]        be_addr_o,
   output logic [cache_bus_pkg::DATA_W-1:0]        be_wdata_o,
   output logic [cache_bus_pkg::NBYTES-1:0]        be_wstrb_o,
   input  logic                                    be_ready_i,
   input  logic [cache_bus_pkg::DATA_W-1:0]        be_rdata_i,
   input  logic                                    be_rvalid_i,
   // monitor
   input  logic                                    invalidate_i,
   output logic                                    rd_hit_o,
   output logic                                    rd_miss_o,
   output logic                                    wr_hit_o,
   output logic                                    wr_miss_o,
   // tag RAM
   output logic                                    tag_en_o,
   output logic [cache_cfg_pkg::NSETS_W-1:0]       tag_addr_o,
   output logic [cache_cfg_pkg::NWAYS-1:0]         tag_we_o,
   output logic [cache_cfg_pkg::NWAYS*cache_cfg_pkg::TAG_W-1:0] tag_d_o,
   input  logic [cache_cfg_pkg::NWAYS*cache_cfg_pkg::TAG_W-1:0] tag_q_i,
   // data RAM
   output logic                                    data_en_o,
   output logic [cache_cfg_pkg::NSETS_W-1:0]       data_addr_o,
   output logic [cache_cfg_pkg::NWAYS*cache_cfg_pkg::WORDS_PER_LINE*cache_bus_pkg::NBYTES-1:0]
                                                   data_we_o,
   output logic [cache_cfg_pkg::NWAYS*cache_bus_pkg::LINE_W-1:0] data_d_o,
   input  logic [cache_cfg_pkg::NWAYS*cache_bus_pkg::LINE_W-1:0] data_q_i,
   // replacement unit
   output logic                                    touch_o,
   output logic [cache_cfg_pkg::NSETS_W-1:0]       touch_set_o,
   output logic [cache_cfg_pkg::NWAYS_W-1:0]       touch_way_o,
   input  logic [cache_cfg_pkg::NWAYS_W-1:0]       replace_way_i
);

   logic [cache_cfg_pkg::ST_W-1:0] state_q, state_d;
   cache_bus_pkg::fe_addr_u fe_addr, req_addr_q, refill_addr;
   logic [cache_bus_pkg::DATA_W-1:0] req_wdata_q, rdata_q;
   logic [cache_bus_pkg::NBYTES-1:0] req_wstrb_q;
   logic [cache_cfg_pkg::NSETS-1:0][cache_cfg_pkg::NWAYS-1:0] valid_q;
   logic [cache_cfg_pkg::WORDS_PER_LINE_W:0] req_cnt_q;
   logic [cache_cfg_pkg::WORDS_PER_LINE_W-1:0] ret_cnt_q;
   logic rvalid_q;
   logic [cache_cfg_pkg::NWAYS-1:0] hit_1hot;
   logic [cache_cfg_pkg::NWAYS_W-1:0] hit_way;
   logic [cache_cfg_pkg::NWAYS*cache_bus_pkg::LINE_W-1:0] rd_shift;
   logic [cache_cfg_pkg::NWAYS*cache_cfg_pkg::WORDS_PER_LINE*cache_bus_pkg::NBYTES-1:0]
      hit_we, refill_we;
   logic idle, lookup, refill, req_rd, hit;
   logic rd_hit, rd_miss, wr_hit, wr_miss;
   logic accept, be_write, be_refill, refill_wr, refill_last;

   assign fe_addr = fe_addr_i;

   assign idle   = (state_q == cache_cfg_pkg::ST_IDLE);
   assign lookup = (state_q == cache_cfg_pkg::ST_LOOKUP);
   assign refill = (state_q == cache_cfg_pkg::ST_REFILL);
   assign req_rd = ~|req_wstrb_q;

   // tag compare on the registered request, gated by valid
   for (genvar w = 0; w < cache_cfg_pkg::NWAYS; w++) begin : g_way
      assign hit_1hot[w] = valid_q[req_addr_q.fields.index][w] &&
         (tag_q_i[w*cache_cfg_pkg::TAG_W +: cache_cfg_pkg::TAG_W] == req_addr_q.fields.tag);
   end

   // one-hot to binary
   always_comb begin
      hit_way = '0;
      for (int w = 0; w < cache_cfg_pkg::NWAYS; w++) begin
         if (hit_1hot[w]) begin
            hit_way = w[cache_cfg_pkg::NWAYS_W-1:0];
         end
      end
   end

   assign hit     = |hit_1hot;
   assign rd_hit  = lookup & req_rd & hit;
   assign rd_miss = lookup & req_rd & ~hit;
   assign wr_hit  = lookup & ~req_rd & hit;
   assign wr_miss = lookup & ~req_rd & ~hit;

   assign rd_hit_o  = rd_hit;
   assign rd_miss_o = rd_miss;
   assign wr_hit_o  = wr_hit;
   assign wr_miss_o = wr_miss;

   // read hits keep the pipe open
   assign fe_ready_o  = idle | rd_hit;
   assign accept      = fe_avalid_i & fe_ready_o;
   assign fe_rvalid_o = rvalid_q;
   assign fe_rdata_o  = rdata_q;

   assign refill_wr   = refill & be_rvalid_i;
   assign refill_last = refill_wr & (&ret_cnt_q);

   // back-end requests
   assign be_write  = (lookup & ~req_rd) | (state_q == cache_cfg_pkg::ST_WRITE);
   assign be_refill = refill & ~req_cnt_q[cache_cfg_pkg::WORDS_PER_LINE_W];

   always_comb begin
      refill_addr = req_addr_q;
      refill_addr.fields.offset = req_cnt_q[cache_cfg_pkg::WORDS_PER_LINE_W-1:0];
   end

   assign be_avalid_o = be_write | be_refill;
   assign be_addr_o   = be_write ? req_addr_q.raw : refill_addr.raw;
   assign be_wdata_o  = req_wdata_q;
   assign be_wstrb_o  = be_write ? req_wstrb_q : '0;

   // byte enables inside the set word, way and word offset side by side
   assign hit_we = {{(cache_cfg_pkg::NWAYS*cache_cfg_pkg::WORDS_PER_LINE-1)
                     *cache_bus_pkg::NBYTES{1'b0}}, req_wstrb_q}
                   << ({hit_way, req_addr_q.fields.offset} * cache_bus_pkg::NBYTES);
   assign refill_we = {{(cache_cfg_pkg::NWAYS*cache_cfg_pkg::WORDS_PER_LINE-1)
                        *cache_bus_pkg::NBYTES{1'b0}}, {cache_bus_pkg::NBYTES{1'b1}}}
                      << ({replace_way_i, ret_cnt_q} * cache_bus_pkg::NBYTES);

   // RAM side
   assign data_en_o   = accept | wr_hit | refill_wr;
   assign data_addr_o = accept ? fe_addr.fields.index : req_addr_q.fields.index;
   assign data_we_o   = wr_hit ? hit_we : (refill_wr ? refill_we : '0);
   assign data_d_o    = wr_hit ?
      {cache_cfg_pkg::NWAYS*cache_cfg_pkg::WORDS_PER_LINE{req_wdata_q}} :
      {cache_cfg_pkg::NWAYS*cache_cfg_pkg::WORDS_PER_LINE{be_rdata_i}};

   assign tag_en_o   = accept | refill_last;
   assign tag_addr_o = accept ? fe_addr.fields.index : req_addr_q.fields.index;
   assign tag_we_o   = {{(cache_cfg_pkg::NWAYS-1){1'b0}}, refill_last} << replace_way_i;
   assign tag_d_o    = {cache_cfg_pkg::NWAYS{req_addr_q.fields.tag}};

   assign rd_shift = data_q_i >> ({hit_way, req_addr_q.fields.offset} * cache_bus_pkg::DATA_W);

   // hits and completed refills update the LRU
   assign touch_o     = rd_hit | wr_hit | refill_last;
   assign touch_set_o = req_addr_q.fields.index;
   assign touch_way_o = refill_last ? replace_way_i : hit_way;

   always_comb begin
      state_d = state_q;
      case (state_q)
         cache_cfg_pkg::ST_IDLE: begin
            if (accept) state_d = cache_cfg_pkg::ST_LOOKUP;
         end
         cache_cfg_pkg::ST_LOOKUP: begin
            if (rd_hit) begin
               state_d = accept ? cache_cfg_pkg::ST_LOOKUP : cache_cfg_pkg::ST_IDLE;
            end else if (rd_miss) begin
               state_d = cache_cfg_pkg::ST_REFILL;
            end else begin
               state_d = be_ready_i ? cache_cfg_pkg::ST_IDLE : cache_cfg_pkg::ST_WRITE;
            end
         end
         cache_cfg_pkg::ST_REFILL: begin
            if (refill_last) state_d = cache_cfg_pkg::ST_IDLE;
         end
         default: begin
            if (be_ready_i) state_d = cache_cfg_pkg::ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= cache_cfg_pkg::ST_IDLE;
         valid_q   <= '0;
         req_cnt_q <= '0;
         ret_cnt_q <= '0;
         rvalid_q  <= 1'b0;
      end else begin
         state_q  <= state_d;
         rvalid_q <= rd_hit | refill_last;
         if (idle && invalidate_i) begin
            valid_q <= '0;
         end else if (refill_last) begin
            valid_q[req_addr_q.fields.index][replace_way_i] <= 1'b1;
         end
         // request and return counters run apart so reads overlap
         if (!refill) begin
            req_cnt_q <= '0;
            ret_cnt_q <= '0;
         end else begin
            if (be_refill && be_ready_i) req_cnt_q <= req_cnt_q + 1'b1;
            if (be_rvalid_i) ret_cnt_q <= ret_cnt_q + 1'b1;
         end
      end
   end

   // request and read data registers
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_addr_q  <= fe_addr;
         req_wdata_q <= fe_wdata_i;
         req_wstrb_q <= fe_wstrb_i;
      end
      if (rd_hit) begin
         rdata_q <= rd_shift[cache_bus_pkg::DATA_W-1:0];
      end else if (refill_wr && ret_cnt_q == req_addr_q.fields.offset) begin
         rdata_q <= be_rdata_i;
      end
   end

endmodule

//--- src/cache_top.sv
`timescale 1ns/1ps

module cache_top (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   // front-end bus
   input  logic                             fe_avalid_i,
   input  logic [cache_bus_pkg::ADDR_W-1:0] fe_addr_i,
   input  logic [cache_bus_pkg::DATA_W-1:0] fe_wdata_i,
   input  logic [cache_bus_pkg::NBYTES-1:0] fe_wstrb_i,
   output logic [cache_bus_pkg::DATA_W-1:0] fe_rdata_o,
   output logic                             fe_rvalid_o,
   output logic                             fe_ready_o,
   // back-end bus
   output logic                             be_avalid_o,
   output logic [cache_bus_pkg::ADDR_W-1:0] be_addr_o,
   output logic [cache_bus_pkg::DATA_W-1:0] be_wdata_o,
   output logic [cache_bus_pkg::NBYTES-1:0] be_wstrb_o,
   input  logic                             be_ready_i,
   input  logic [cache_bus_pkg::DATA_W-1:0] be_rdata_i,
   input  logic                             be_rvalid_i,
   // monitor
   input  logic                             invalidate_i,
   output logic                             rd_hit_o,
   output logic                             rd_miss_o,
   output logic                             wr_hit_o,
   output logic                             wr_miss_o
);

   logic                                                   tag_en;
   logic [cache_cfg_pkg::NSETS_W-1:0]                      tag_addr;
   logic [cache_cfg_pkg::NWAYS-1:0]                        tag_we;
   logic [cache_cfg_pkg::NWAYS*cache_cfg_pkg::TAG_W-1:0]   tag_d, tag_q;
   logic                                                   data_en;
   logic [cache_cfg_pkg::NSETS_W-1:0]                      data_addr;
   logic [cache_cfg_pkg::NWAYS*cache_cfg_pkg::WORDS_PER_LINE*cache_bus_pkg::NBYTES-1:0]
                                                           data_we;
   logic [cache_cfg_pkg::NWAYS*cache_bus_pkg::LINE_W-1:0]  data_d, data_q;
   logic                                                   touch;
   logic [cache_cfg_pkg::NSETS_W-1:0]                      touch_set;
   logic [cache_cfg_pkg::NWAYS_W-1:0]                      touch_way, replace_way;

   cache_ctrl ctrl_i (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .fe_avalid_i   (fe_avalid_i),
      .fe_addr_i     (fe_addr_i),
      .fe_wdata_i    (fe_wdata_i),
      .fe_wstrb_i    (fe_wstrb_i),
      .fe_rdata_o    (fe_rdata_o),
      .fe_rvalid_o   (fe_rvalid_o),
      .fe_ready_o    (fe_ready_o),
      .be_avalid_o   (be_avalid_o),
      .be_addr_o     (be_addr_o),
      .be_wdata_o    (be_wdata_o),
      .be_wstrb_o    (be_wstrb_o),
      .be_ready_i    (be_ready_i),
      .be_rdata_i    (be_rdata_i),
      .be_rvalid_i   (be_rvalid_i),
      .invalidate_i  (invalidate_i),
      .rd_hit_o      (rd_hit_o),
      .rd_miss_o     (rd_miss_o),
      .wr_hit_o      (wr_hit_o),
      .wr_miss_o     (wr_miss_o),
      .tag_en_o      (tag_en),
      .tag_addr_o    (tag_addr),
      .tag_we_o      (tag_we),
      .tag_d_o       (tag_d),
      .tag_q_i       (tag_q),
      .data_en_o     (data_en),
      .data_addr_o   (data_addr),
      .data_we_o     (data_we),
      .data_d_o      (data_d),
      .data_q_i      (data_q),
      .touch_o       (touch),
      .touch_set_o   (touch_set),
      .touch_way_o   (touch_way),
      .replace_way_i (replace_way)
   );

   // victim lookup follows the set of the registered request
   cache_replace replace_i (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .set_i         (touch_set),
      .replace_way_o (replace_way),
      .touch_i       (touch),
      .touch_set_i   (touch_set),
      .touch_way_i   (touch_way)
   );

   // all tags of one set, written per way
   cache_sp_ram #(
      .WORD_W  (cache_cfg_pkg::NWAYS * cache_cfg_pkg::TAG_W),
      .DEPTH_W (cache_cfg_pkg::NSETS_W),
      .NGROUPS (cache_cfg_pkg::NWAYS)
   ) tag_ram_i (
      .clk_i  (clk_i),
      .en_i   (tag_en),
      .addr_i (tag_addr),
      .we_i   (tag_we),
      .d_i    (tag_d),
      .q_o    (tag_q)
   );

   // all lines of one set, written per byte
   cache_sp_ram #(
      .WORD_W  (cache_cfg_pkg::NWAYS * cache_bus_pkg::LINE_W),
      .DEPTH_W (cache_cfg_pkg::NSETS_W),
      .NGROUPS (cache_cfg_pkg::NWAYS * cache_cfg_pkg::WORDS_PER_LINE * cache_bus_pkg::NBYTES)
   ) data_ram_i (
      .clk_i  (clk_i),
      .en_i   (data_en),
      .addr_i (data_addr),
      .we_i   (data_we),
      .d_i    (data_d),
      .q_o    (data_q)
   );

endmodule

//--- bench/tb_backend_mem.sv
`timescale 1ns/1ps

module tb_backend_mem (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             avalid_i,
   input  logic [cache_bus_pkg::ADDR_W-1:0] addr_i,
   input  logic [cache_bus_pkg::DATA_W-1:0] wdata_i,
   input  logic [cache_bus_pkg::NBYTES-1:0] wstrb_i,
   output logic                             ready_o,
   output logic [cache_bus_pkg::DATA_W-1:0] rdata_o,
   output logic                             rvalid_o
);

   logic [cache_bus_pkg::DATA_W-1:0] mem [2**cache_bus_pkg::ADDR_W];
   // read responses waiting for their cycle
   logic [cache_bus_pkg::DATA_W-1:0] rsp_data [$];
   int rsp_due [$];
   int seed;
   int cyc;
   int due;
   int last_due;

   initial begin
      seed     = 32'h40f3;
      ready_o  = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      cyc      = 0;
      last_due = 0;
      for (int a = 0; a < 2**cache_bus_pkg::ADDR_W; a++) begin
         mem[a] = a * 32'h0001_0003 + 32'h5A00_0000;
      end
   end

   // take requests at the rising edge
   always @(posedge clk_i) begin
      cyc = cyc + 1;
      if (arst_n_i && avalid_i && ready_o) begin
         if (wstrb_i != '0) begin
            for (int b = 0; b < cache_bus_pkg::NBYTES; b++) begin
               if (wstrb_i[b]) begin
                  mem[addr_i][8*b +: 8] = wdata_i[8*b +: 8];
               end
            end
         end else begin
            // responses stay in order, at most one per cycle
            due = cyc + 2 + ($random(seed) & 3);
            if (due <= last_due) begin
               due = last_due + 1;
            end
            last_due = due;
            rsp_data.push_back(mem[addr_i]);
            rsp_due.push_back(due);
         end
      end
   end

   // outputs change on the falling edge
   always @(negedge clk_i) begin
      ready_o  = arst_n_i && (($random(seed) & 3) != 0);
      rvalid_o = 1'b0;
      if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
         rvalid_o = 1'b1;
         rdata_o  = rsp_data.pop_front();
         void'(rsp_due.pop_front());
      end
   end

endmodule

//--- bench/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

   localparam int TIMEOUT_CYC = 200;

   logic                             clk;
   logic                             arst_n;
   logic                             fe_avalid;
   logic [cache_bus_pkg::ADDR_W-1:0] fe_addr;
   logic [cache_bus_pkg::DATA_W-1:0] fe_wdata;
   logic [cache_bus_pkg::NBYTES-1:0] fe_wstrb;
   logic [cache_bus_pkg::DATA_W-1:0] fe_rdata_o;
   logic                             fe_rvalid_o;
   logic                             fe_ready_o;
   logic                             be_avalid, be_ready, be_rvalid;
   logic [cache_bus_pkg::ADDR_W-1:0] be_addr;
   logic [cache_bus_pkg::DATA_W-1:0] be_wdata, be_rdata;
   logic [cache_bus_pkg::NBYTES-1:0] be_wstrb;
   logic                             invalidate;
   logic                             rd_hit, rd_miss, wr_hit, wr_miss;

   // operations from the stimulus file
   string                            op_kind [$];
   cache_bus_pkg::fe_addr_u          op_addr [$];
   logic [cache_bus_pkg::DATA_W-1:0] op_wdata [$];
   logic [cache_bus_pkg::NBYTES-1:0] op_wstrb [$];
   logic [cache_bus_pkg::DATA_W-1:0] op_exp [$];
   int                               ops_done;
   int                               i;
   int                               j;

   cache_top cache_top_i (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .fe_avalid_i  (fe_avalid),
      .fe_addr_i    (fe_addr),
      .fe_wdata_i   (fe_wdata),
      .fe_wstrb_i   (fe_wstrb),
      .fe_rdata_o   (fe_rdata_o),
      .fe_rvalid_o  (fe_rvalid_o),
      .fe_ready_o   (fe_ready_o),
      .be_avalid_o  (be_avalid),
      .be_addr_o    (be_addr),
      .be_wdata_o   (be_wdata),
      .be_wstrb_o   (be_wstrb),
      .be_ready_i   (be_ready),
      .be_rdata_i   (be_rdata),
      .be_rvalid_i  (be_rvalid),
      .invalidate_i (invalidate),
      .rd_hit_o     (rd_hit),
      .rd_miss_o    (rd_miss),
      .wr_hit_o     (wr_hit),
      .wr_miss_o    (wr_miss)
   );

   tb_backend_mem mem_i (
      .clk_i    (clk),
      .arst_n_i (arst_n),
      .avalid_i (be_avalid),
      .addr_i   (be_addr),
      .wdata_i  (be_wdata),
      .wstrb_i  (be_wstrb),
      .ready_o  (be_ready),
      .rdata_o  (be_rdata),
      .rvalid_o (be_rvalid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input logic [cache_bus_pkg::DATA_W-1:0] exp,
                             input logic [cache_bus_pkg::DATA_W-1:0] act);
      if (act !== exp) begin
         report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
      end
   endtask

   // bits are rd_hit, rd_miss, wr_hit, wr_miss
   task automatic check_mon(input logic [3:0] exp, input logic [3:0] act);
      if (act !== exp) begin
         report_failure($sformatf("ERR monitor expected %h actual %h", exp, act));
      end
   endtask

   function automatic logic [3:0] expected_mon(input string kind);
      if (kind == "RH" || kind == "PH") return 4'b1000;
      if (kind == "RM") return 4'b0100;
      if (kind == "WH") return 4'b0010;
      return 4'b0001;
   endfunction

   task automatic load_stimulus();
      int fd;
      int rc;
      string line;
      string kind;
      logic [31:0] tag, idx, off, wdata, strb, exp;
      cache_bus_pkg::fe_addr_u a;
      fd = $fopen("bench/cache_stimulus.txt", "r");
      if (fd == 0) report_failure("could not open the stimulus file");
      while (!$feof(fd)) begin
         line = "";
         rc = $fgets(line, fd);
         if (rc == 0) break;
         if (line.len() < 2 || line[0] == "#") continue;
         rc = $sscanf(line, "%s %h %h %h %h %h %h", kind, tag, idx, off, wdata, strb, exp);
         if (rc != 7) report_failure($sformatf("bad stimulus line: %s", line));
         a.fields.tag    = tag[cache_cfg_pkg::TAG_W-1:0];
         a.fields.index  = idx[cache_cfg_pkg::NSETS_W-1:0];
         a.fields.offset = off[cache_cfg_pkg::WORDS_PER_LINE_W-1:0];
         op_kind.push_back(kind);
         op_addr.push_back(a);
         op_wdata.push_back(wdata);
         op_wstrb.push_back(strb[cache_bus_pkg::NBYTES-1:0]);
         op_exp.push_back(exp);
      end
      $fclose(fd);
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (fe_ready_o !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT_CYC) report_failure("timeout waiting for fe_ready_o");
      end
   endtask

   task automatic wait_rvalid();
      int n;
      n = 0;
      while (fe_rvalid_o !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > TIMEOUT_CYC) report_failure("timeout waiting for fe_rvalid_o");
      end
   endtask

   // drive one request and leave the bus once it is taken
   task automatic issue_request(input int k);
      fe_avalid = 1'b1;
      fe_addr   = op_addr[k].raw;
      fe_wdata  = op_wdata[k];
      fe_wstrb  = (op_kind[k][0] == "W") ? op_wstrb[k] : '0;
      wait_ready();
      @(negedge clk);
      fe_avalid = 1'b0;
      fe_wstrb  = '0;
   endtask

   task automatic run_single(input int k);
      issue_request(k);
      check_mon(expected_mon(op_kind[k]), {rd_hit, rd_miss, wr_hit, wr_miss});
      if (op_kind[k] == "RH") begin
         @(negedge clk);
         if (fe_rvalid_o !== 1'b1) report_failure("read hit data not one cycle after accept");
         check_data("fe_rdata_o", op_exp[k], fe_rdata_o);
      end else if (op_kind[k] == "RM") begin
         wait_rvalid();
         check_data("fe_rdata_o", op_exp[k], fe_rdata_o);
      end else begin
         wait_ready();
      end
   endtask

   // back-to-back hits with data one cycle after each accept
   task automatic run_pipeline(input int first, input int last);
      int n;
      n = last - first + 1;
      for (int c = 0; c <= n + 1; c++) begin
         if (c >= 1 && c <= n) begin
            check_mon(expected_mon(op_kind[first+c-1]), {rd_hit, rd_miss, wr_hit, wr_miss});
         end
         if (c >= 2) begin
            if (fe_rvalid_o !== 1'b1) report_failure("pipelined read data missing");
            check_data("fe_rdata_o", op_exp[first+c-2], fe_rdata_o);
         end
         if (c < n) begin
            if (fe_ready_o !== 1'b1) report_failure("fe_ready_o dropped during read hits");
            fe_avalid = 1'b1;
            fe_addr   = op_addr[first+c].raw;
         end else begin
            fe_avalid = 1'b0;
         end
         @(negedge clk);
      end
   endtask

   initial begin
      arst_n     = 1'b0;
      fe_avalid  = 1'b0;
      fe_addr    = '0;
      fe_wdata   = '0;
      fe_wstrb   = '0;
      invalidate = 1'b0;
      ops_done   = 0;
      load_stimulus();
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      i = 0;
      while (i < op_kind.size()) begin
         if (op_kind[i] == "PH") begin
            j = i;
            while (j < op_kind.size() && op_kind[j] == "PH") j++;
            run_pipeline(i, j - 1);
            ops_done += j - i;
            i = j;
         end else begin
            if (op_kind[i] == "IV") begin
               wait_ready();
               invalidate = 1'b1;
               @(negedge clk);
               invalidate = 1'b0;
            end else if (op_kind[i] == "MC") begin
               wait_ready();
               check_data("backend mem", op_exp[i], mem_i.mem[op_addr[i].raw]);
            end else if (op_kind[i] == "RH" || op_kind[i] == "RM" ||
                         op_kind[i] == "WH" || op_kind[i] == "WM") begin
               run_single(i);
            end else begin
               report_failure($sformatf("unknown operation kind %s", op_kind[i]));
            end
            ops_done++;
            i++;
         end
      end
      if (ops_done > 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         report_failure("no operations were run");
      end
   end

endmodule

//--- bench/cache_stimulus.txt
# kind tag index offset wdata strobe expected, all hex
# kinds RH/RM read hit/miss, WH/WM write hit/miss, MC memory check, IV invalidate, PH pipelined hit
RM 00 1 0 00000000 0 5A04000C
RH 00 1 1 00000000 0 5A05000F
RH 00 1 2 00000000 0 5A060012
RH 00 1 3 00000000 0 5A070015
WH 00 1 2 AABBCCDD 5 00000000
RH 00 1 2 00000000 0 5ABB00DD
MC 00 1 2 00000000 0 5ABB00DD
WM 01 2 1 12345678 F 00000000
MC 01 2 1 00000000 0 12345678
RM 01 2 1 00000000 0 12345678
RH 01 2 0 00000000 0 5A280078
RM 02 5 0 00000000 0 5A5400FC
RM 03 5 0 00000000 0 5A74015C
RH 02 5 0 00000000 0 5A5400FC
RM 04 5 0 00000000 0 5A9401BC
RH 02 5 0 00000000 0 5A5400FC
RM 03 5 0 00000000 0 5A74015C
PH 00 1 0 00000000 0 5A04000C
PH 00 1 1 00000000 0 5A05000F
PH 00 1 3 00000000 0 5A070015
PH 02 5 0 00000000 0 5A5400FC
PH 03 5 0 00000000 0 5A74015C
PH 00 1 2 00000000 0 5ABB00DD
PH 01 2 1 00000000 0 12345678
IV 00 0 0 00000000 0 00000000
RM 00 1 0 00000000 0 5A04000C
RH 00 1 2 00000000 0 5ABB00DD

//--- src.f
common/cache_cfg_pkg.sv
common/cache_bus_pkg.sv
src/cache_sp_ram.sv
cache/cache_replace.sv
cache/cache_ctrl.sv
src/cache_top.sv
bench/tb_backend_mem.sv
bench/tb_cache.sv

//--- Makefile
SIM := obj_dir/Vtb_cache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_cache -f src.f

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
